//--- core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN       32 // one machine word.
`define REG_COUNT  32
`define DMEM_WORDS 64 // data memory depth in words.
`define IMEM_AW    8  // instruction memory word address bits.

`endif

//--- core_pkg.sv
`include "core_config.svh"

package core_pkg;

    localparam int REG_AW = $clog2(`REG_COUNT);

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10 // used by lui.
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_src_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        alu_src;   // second operand is the immediate.
        logic        branch;
        logic        jump;      // set for both jal and jalr.
        logic        jalr;
        result_src_t result_src;
        alu_op_t     alu_op;
        logic [2:0]  funct3;
        logic        rs1_used;
        logic        rs2_used;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rd1;
        word_t     rd2;
        word_t     imm_ext;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } de_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_t result_src;
        logic [2:0]  funct3;
        word_t       alu_result;
        word_t       store_data;
        word_t       pc_plus4;
        reg_addr_t   rd;
    } ew_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

//--- control_unit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module control_unit import core_pkg::*; (
    input  logic [`XLEN-1:0] instr,
    output ctrl_t            ctrl,
    output imm_src_t         imm_src
);

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    function automatic alu_op_t alu_decode(input logic [2:0] f3,
                                           input logic       f7_b5,
                                           input logic       is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (is_reg && f7_b5) ? ALU_SUB : ALU_ADD; // addi has no sub form.
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = f7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl            = '0;
        ctrl.alu_op     = ALU_ADD;
        ctrl.result_src = RES_ALU;
        ctrl.funct3     = funct3;
        imm_src         = IMM_I;
        case (opcode)
            OP_R, OP_I: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = (opcode == OP_I);
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = (opcode == OP_R);
                ctrl.alu_op    = alu_decode(funct3, funct7_b5, opcode == OP_R);
            end
            OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = RES_MEM;
                ctrl.rs1_used   = 1'b1;
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = 1'b1;
                imm_src        = IMM_S;
            end
            OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
                ctrl.alu_op   = funct3[2] ? ALU_SLT : ALU_SUB; // blt/bge compare, beq/bne subtract.
                imm_src       = IMM_B;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm_src        = IMM_U;
            end
            OP_JAL, OP_JALR: begin
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.jalr       = (opcode == OP_JALR);
                ctrl.alu_src    = 1'b1; // the alu forms rs1 + imm for jalr.
                ctrl.rs1_used   = (opcode == OP_JALR);
                ctrl.result_src = RES_PC4;
                imm_src         = (opcode == OP_JAL) ? IMM_J : IMM_I;
            end
            default: ; // unsupported opcodes decode as a no-op.
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file import core_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [4:0]       a1,
    input  logic [4:0]       a2,
    input  wb_t              wb,
    output logic [`XLEN-1:0] dout1,
    output logic [`XLEN-1:0] dout2,
    output logic [`XLEN-1:0] a0
);

    word_t regs [1:`REG_COUNT-1]; // x0 has no storage.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // a write in this cycle is passed straight to the reader.
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wb.valid && wb.rd == addr) begin
            data = wb.value;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign dout1 = read_port(a1);
    assign dout2 = read_port(a2);
    assign a0    = regs[10];

endmodule

//--- decode.sv
`timescale 1ns/1ps
`include "core_config.svh"

module decode import core_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  fd_t              fd,
    input  logic             fd_valid,
    input  wb_t              wb,
    output de_t              de,
    output logic [`XLEN-1:0] a0
);

    ctrl_t      ctrl;
    imm_src_t   imm_src;
    word_t      imm_ext;
    word_t      rd1;
    word_t      rd2;
    logic [31:0] ins;

    assign ins = fd.instr;

    control_unit cu_i (
        .instr   (fd.instr),
        .ctrl    (ctrl),
        .imm_src (imm_src)
    );

    reg_file rf_i (
        .clk    (clk),
        .arst_n (arst_n),
        .a1     (ins[19:15]),
        .a2     (ins[24:20]),
        .wb     (wb),
        .dout1  (rd1),
        .dout2  (rd2),
        .a0     (a0)
    );

    always_comb begin
        case (imm_src)
            IMM_I: begin
                imm_ext = {{20{ins[31]}}, ins[31:20]};
            end
            IMM_S: begin
                imm_ext = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            IMM_B: begin
                imm_ext = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            IMM_U: begin
                imm_ext = {ins[31:12], 12'b0};
            end
            IMM_J: begin
                imm_ext = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: begin
                imm_ext = '0;
            end
        endcase
    end

    always_comb begin
        de                = '0;
        de.ctrl           = ctrl;
        de.ctrl.reg_write = ctrl.reg_write & fd_valid; // a bubble must not write.
        de.ctrl.mem_write = ctrl.mem_write & fd_valid;
        de.pc             = fd.pc;
        de.rd1            = rd1;
        de.rd2            = rd2;
        de.imm_ext        = imm_ext;
        de.rd             = ins[11:7];
        de.rs1            = ins[19:15];
        de.rs2            = ins[24:20];
    end

endmodule

//--- pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t payload_in,
    output logic     valid_out,
    output payload_t payload_out
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out   <= 1'b0;
            payload_out <= '0;
        end else begin
            valid_out   <= valid_in & ~flush; // a flushed slot becomes a bubble.
            payload_out <= payload_in;
        end
    end

endmodule

//--- execute.sv
`timescale 1ns/1ps
`include "core_config.svh"

module execute import core_pkg::*; (
    input  de_t       de,
    input  logic      de_valid,
    input  wb_t       wb,
    output ew_t       ew,
    output redirect_t redirect
);

    localparam int SHAMT_W = $clog2(`XLEN);

    word_t src_a;
    word_t rs2_val;
    word_t src_b;
    word_t alu_result;
    logic  cond;

    // the result stage holds the only instruction that can be newer than the file.
    function automatic word_t forward(input reg_addr_t rs, input logic used, input word_t rf_val);
        return (used && wb.valid && wb.rd != '0 && wb.rd == rs) ? wb.value : rf_val;
    endfunction

    assign src_a   = forward(de.rs1, de.ctrl.rs1_used, de.rd1);
    assign rs2_val = forward(de.rs2, de.ctrl.rs2_used, de.rd2);
    assign src_b   = de.ctrl.alu_src ? de.imm_ext : rs2_val;

    always_comb begin
        case (de.ctrl.alu_op)
            ALU_ADD:    alu_result = src_a + src_b;
            ALU_SUB:    alu_result = src_a - src_b;
            ALU_AND:    alu_result = src_a & src_b;
            ALU_OR:     alu_result = src_a | src_b;
            ALU_XOR:    alu_result = src_a ^ src_b;
            ALU_SLT:    alu_result = word_t'($signed(src_a) < $signed(src_b));
            ALU_SLTU:   alu_result = word_t'(src_a < src_b);
            ALU_SLL:    alu_result = src_a << src_b[SHAMT_W-1:0];
            ALU_SRL:    alu_result = src_a >> src_b[SHAMT_W-1:0];
            ALU_SRA:    alu_result = word_t'($signed(src_a) >>> src_b[SHAMT_W-1:0]);
            ALU_PASS_B: alu_result = src_b;
            default:    alu_result = '0;
        endcase
    end

    // funct3 bit 2 picks less-than over equality, bit 0 inverts the test.
    assign cond = de.ctrl.funct3[0] ^ (de.ctrl.funct3[2] ? alu_result[0] : (alu_result == '0));

    always_comb begin
        redirect.taken  = de_valid && (de.ctrl.jump || (de.ctrl.branch && cond));
        redirect.target = de.ctrl.jalr ? {alu_result[`XLEN-1:1], 1'b0} : de.pc + de.imm_ext;
    end

    always_comb begin
        ew.reg_write  = de.ctrl.reg_write & de_valid;
        ew.mem_write  = de.ctrl.mem_write & de_valid;
        ew.result_src = de.ctrl.result_src;
        ew.funct3     = de.ctrl.funct3;
        ew.alu_result = alu_result;
        ew.store_data = rs2_val; // forwarded store data.
        ew.pc_plus4   = de.pc + word_t'(4);
        ew.rd         = de.rd;
    end

endmodule

//--- result.sv
`timescale 1ns/1ps
`include "core_config.svh"

module result import core_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  ew_t  ew,
    input  logic ew_valid,
    output wb_t  wb
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    word_t              dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic               word_access;
    word_t              load_word;

    assign idx         = ew.alu_result[DMEM_AW+1:2];
    assign word_access = (ew.funct3 == 3'b010); // only lw and sw are supported.
    assign load_word   = word_access ? dmem[idx] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ew_valid && ew.mem_write && word_access) begin
            dmem[idx] <= ew.store_data;
        end
    end

    always_comb begin
        wb.valid = ew_valid && ew.reg_write;
        wb.rd    = ew.rd;
        case (ew.result_src)
            RES_MEM: wb.value = load_word;
            RES_PC4: wb.value = ew.pc_plus4;
            default: wb.value = ew.alu_result;
        endcase
    end

endmodule

//--- fetch.sv
`timescale 1ns/1ps
`include "core_config.svh"

module fetch import core_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  redirect_t           redirect,
    input  logic [`XLEN-1:0]    instr,
    output logic [`IMEM_AW-1:0] instr_addr,
    output fd_t                 fd
);

    word_t pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= redirect.taken ? redirect.target : pc + word_t'(4);
        end
    end

    assign instr_addr = pc[`IMEM_AW+1:2]; // byte address to word address.
    assign fd.pc      = pc;
    assign fd.instr   = instr;

endmodule

//--- core_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_top import core_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [`XLEN-1:0]    instr,
    output logic [`IMEM_AW-1:0] instr_addr,
    output wb_t                 wb,
    output logic [`XLEN-1:0]    a0
);

    fd_t       fd_f;
    fd_t       fd_d;
    de_t       de_d;
    de_t       de_e;
    ew_t       ew_e;
    ew_t       ew_w;
    redirect_t redirect;
    logic      fd_valid;
    logic      de_valid;
    logic      ew_valid;

    fetch fetch_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .redirect   (redirect),
        .instr      (instr),
        .instr_addr (instr_addr),
        .fd         (fd_f)
    );

    pipe_reg #(.payload_t(fd_t)) fd_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (redirect.taken),
        .valid_in    (1'b1), // fetch always has an instruction.
        .payload_in  (fd_f),
        .valid_out   (fd_valid),
        .payload_out (fd_d)
    );

    decode decode_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .fd       (fd_d),
        .fd_valid (fd_valid),
        .wb       (wb),
        .de       (de_d),
        .a0       (a0)
    );

    pipe_reg #(.payload_t(de_t)) de_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (redirect.taken),
        .valid_in    (fd_valid),
        .payload_in  (de_d),
        .valid_out   (de_valid),
        .payload_out (de_e)
    );

    execute execute_i (
        .de       (de_e),
        .de_valid (de_valid),
        .wb       (wb),
        .ew       (ew_e),
        .redirect (redirect)
    );

    pipe_reg #(.payload_t(ew_t)) ew_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (1'b0), // the branch itself always retires.
        .valid_in    (de_valid),
        .payload_in  (ew_e),
        .valid_out   (ew_valid),
        .payload_out (ew_w)
    );

    result result_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .ew       (ew_w),
        .ew_valid (ew_valid),
        .wb       (wb)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- core_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_tb import core_pkg::*; ();

    localparam int NT = 6;
    localparam int MAXW = 64;

    logic clk;
    logic por_n;
    logic rst_n = 1'b0;
    logic [`XLEN-1:0] instr;
    logic [`IMEM_AW-1:0] instr_addr;
    wb_t wb;
    logic [`XLEN-1:0] a0;
    logic [31:0] imem [2**`IMEM_AW];
    logic [31:0] prog [NT][MAXW];
    logic [4:0] exp_rd [NT][MAXW];
    logic [31:0] exp_val [NT][MAXW];
    logic [31:0] exp_a0 [NT];
    int plen [NT];
    int exp_n [NT];
    int budget [NT];
    string tname [NT];
    logic [31:0] lfsr = 32'h79ff4e39;
    int errors = 0;
    int passed = 0;
    int cur;
    bit table_ready = 0;

    tb_clock clk_i (.clk(clk), .arst_n(por_n));

    core_top dut_i (
        .clk        (clk),
        .arst_n     (por_n & rst_n),
        .instr      (instr),
        .instr_addr (instr_addr),
        .wb         (wb),
        .a0         (a0)
    );

    assign instr = imem[instr_addr]; // combinational instruction memory.

    function automatic logic [31:0] r_op(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_op(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                         logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] sw_op(logic [11:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_op(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_op(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    // rv32i semantics of the op and op-imm groups.
    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic draw(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1; // galois step per bit.
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic emit(input logic [31:0] w);
        prog[cur][plen[cur]] = w;
        plen[cur]++;
    endtask

    task automatic expect_wb(input int rd, input logic [31:0] v);
        exp_rd[cur][exp_n[cur]]  = 5'(rd);
        exp_val[cur][exp_n[cur]] = v;
        exp_n[cur]++;
    endtask

    task automatic emit_checked(input logic [31:0] w, input int rd, input logic [31:0] v);
        emit(w);
        expect_wb(rd, v);
    endtask

    task automatic load_value(input int rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12; // compensates the sign of the low part.
        emit({hi[19:0], 5'(rd), 7'b0110111});
        expect_wb(rd, hi << 12);
        emit(i_op(v[11:0], rd, 3'd0, rd, 7'b0010011));
        expect_wb(rd, v);
    endtask

    task automatic start_test(input int t, input string name, input logic [31:0] a0_val);
        cur = t;
        tname[t] = name;
        exp_a0[t] = a0_val;
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [2:0] f3s [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic alts [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        draw(32, a);
        draw(32, b);
        start_test(0, "alu random", a + b);
        load_value(1, a);
        load_value(2, b);
        for (int i = 0; i < 10; i++) begin
            emit(r_op(alts[i] ? 7'h20 : 7'h00, 2, 1, f3s[i], 3 + i));
            expect_wb(3 + i, alu_ref(f3s[i], alts[i], a, b));
        end
        for (int i = 1; i < 10; i++) begin
            draw(12, imm);
            if (f3s[i] == 3'd1 || f3s[i] == 3'd5) begin
                imm[11:0] = {alts[i] ? 7'h20 : 7'h00, imm[4:0]};
            end
            emit(i_op(imm[11:0], 1, f3s[i], 12 + i, 7'b0010011));
            // op-imm has no subtract, so only a shift uses the alternate form.
            expect_wb(12 + i, alu_ref(f3s[i], alts[i] && f3s[i] == 3'd5, a,
                                      {{20{imm[11]}}, imm[11:0]}));
        end
        emit(r_op(7'h00, 2, 1, 3'd0, 10));
        expect_wb(10, a + b);
        start_test(1, "dependencies", 32'd5);
        emit_checked(i_op(12'd5, 0, 3'd0, 1, 7'b0010011), 1, 5);
        emit_checked(i_op(12'd3, 1, 3'd0, 2, 7'b0010011), 2, 8);
        emit_checked(i_op(12'd1, 0, 3'd0, 5, 7'b0010011), 5, 1);
        emit_checked(r_op(7'h00, 2, 1, 3'd0, 3), 3, 13);
        emit_checked(r_op(7'h20, 2, 3, 3'd0, 10), 10, 5);
        start_test(2, "load store", 32'd187);
        emit_checked(i_op(12'h40, 0, 3'd0, 1, 7'b0010011), 1, 64);
        emit_checked(i_op(12'd123, 0, 3'd0, 2, 7'b0010011), 2, 123);
        emit(sw_op(12'd0, 2, 1));
        emit(sw_op(12'd4, 1, 1));
        emit_checked(i_op(12'd0, 1, 3'd2, 3, 7'b0000011), 3, 123);
        emit_checked(i_op(12'd4, 1, 3'd2, 4, 7'b0000011), 4, 64);
        emit_checked(r_op(7'h00, 4, 3, 3'd0, 10), 10, 187);
        start_test(3, "branches", 32'd7);
        emit_checked(i_op(12'd1, 0, 3'd0, 1, 7'b0010011), 1, 1);
        emit_checked(i_op(12'd2, 0, 3'd0, 2, 7'b0010011), 2, 2);
        emit(b_op(13'd8, 2, 1, 3'd0));
        emit_checked(i_op(12'd3, 0, 3'd0, 3, 7'b0010011), 3, 3);
        emit(b_op(13'd12, 2, 1, 3'd1));
        emit(i_op(12'd99, 0, 3'd0, 4, 7'b0010011));
        emit(i_op(12'd98, 0, 3'd0, 4, 7'b0010011));
        emit(b_op(13'd12, 2, 1, 3'd4));
        emit(i_op(12'd99, 0, 3'd0, 5, 7'b0010011));
        emit(i_op(12'd98, 0, 3'd0, 5, 7'b0010011));
        emit(b_op(13'd8, 2, 1, 3'd5));
        emit_checked(i_op(12'd7, 0, 3'd0, 10, 7'b0010011), 10, 7);
        emit(b_op(13'd12, 1, 2, 3'd5));
        emit(i_op(12'd99, 0, 3'd0, 10, 7'b0010011));
        emit(i_op(12'd98, 0, 3'd0, 10, 7'b0010011));
        emit(b_op(13'd8, 1, 2, 3'd4));
        emit_checked(i_op(12'd6, 0, 3'd0, 6, 7'b0010011), 6, 6);
        emit(b_op(13'd12, 1, 1, 3'd0));
        emit(i_op(12'd99, 0, 3'd0, 7, 7'b0010011));
        emit(i_op(12'd98, 0, 3'd0, 7, 7'b0010011));
        emit(b_op(13'd8, 1, 1, 3'd1));
        emit_checked(i_op(12'd9, 0, 3'd0, 7, 7'b0010011), 7, 9);
        start_test(4, "jumps", 32'd12);
        emit_checked(i_op(12'd0, 0, 3'd0, 10, 7'b0010011), 10, 0);
        emit_checked(jal_op(21'd12, 1), 1, 8);
        emit(i_op(12'd100, 10, 3'd0, 10, 7'b0010011));
        emit(i_op(12'd200, 10, 3'd0, 10, 7'b0010011));
        emit_checked(i_op(12'd5, 10, 3'd0, 10, 7'b0010011), 10, 5);
        emit_checked(i_op(12'd32, 0, 3'd0, 2, 7'b0010011), 2, 32);
        emit_checked(i_op(12'd0, 2, 3'd0, 3, 7'b1100111), 3, 28);
        emit(i_op(12'd1000, 10, 3'd0, 10, 7'b0010011));
        emit_checked(i_op(12'd7, 10, 3'd0, 10, 7'b0010011), 10, 12);
        start_test(5, "x0 writes", 32'd1);
        emit_checked(i_op(12'd5, 0, 3'd0, 0, 7'b0010011), 0, 5); // shown but discarded.
        emit_checked(i_op(12'd1, 0, 3'd0, 1, 7'b0010011), 1, 1);
        emit_checked(r_op(7'h00, 1, 0, 3'd0, 10), 10, 1);
        for (int t = 0; t < NT; t++) budget[t] = plen[t] + 8;
    endtask

    task automatic run_test(input int t);
        int n;
        int first;
        int errs_before;
        errs_before = errors;
        n = 0;
        first = -1;
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < 2**`IMEM_AW; i++) imem[i] = (i < plen[t]) ? prog[t][i] : 32'h0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int c = 1; c <= budget[t]; c++) begin
            @(negedge clk);
            if (wb.valid) begin
                if (first < 0) first = c;
                assert (n < exp_n[t]) else begin
                    $display("%s: unexpected extra write-back to x%0d", tname[t], wb.rd);
                    errors++;
                end
                if (n < exp_n[t]) begin
                    assert (wb.rd == exp_rd[t][n] && wb.value == exp_val[t][n]) else begin
                        $display("ERROR %0t: %s wb %0d got x%0d=%h, expected x%0d=%h", $time,
                                 tname[t], n, wb.rd, wb.value, exp_rd[t][n], exp_val[t][n]);
                        errors++;
                    end
                end
                n++;
            end
        end
        assert (first == 3) else begin
            $display("ERROR %0t: %s first wb in cycle %0d, expected 3", $time, tname[t], first);
            errors++;
        end
        assert (n >= exp_n[t]) else begin
            $display("%s: missing write-backs, only %0d of %0d seen", tname[t], n, exp_n[t]);
            errors++;
        end
        assert (a0 == exp_a0[t]) else begin
            $display("ERROR %0t: %s a0 is %h, expected %h", $time, tname[t], a0, exp_a0[t]);
            errors++;
        end
        if (errors == errs_before) passed++;
        $display("test %0d %s: %0d write-backs, %s", t, tname[t], n,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        for (int i = 0; i < 2**`IMEM_AW; i++) imem[i] = 32'h0;
        for (int t = 0; t < NT; t++) begin
            plen[t]  = 0;
            exp_n[t] = 0;
        end
        build_table();
        table_ready = 1;
        @(posedge por_n);
        for (int t = 0; t < NT; t++) run_test(t);
        $display("%0d of %0d tests passed, %0d errors", passed, NT, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        longint limit;
        wait (table_ready);
        limit = 5 + 20; // power-on reset plus a margin, in cycles.
        for (int t = 0; t < NT; t++) limit += budget[t] + 6;
        #(limit * 100);
        $display("watchdog expired after %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
core_pkg.sv
control_unit.sv
reg_file.sv
decode.sv
pipe_reg.sv
execute.sv
result.sv
fetch.sv
core_top.sv
tb_clock.sv
core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module core_tb -o core_sim
out=$(./obj_dir/core_sim)
echo "$out"
if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
